//--- build.f
verilog/issue_pkg.sv
verilog/instr_decode.sv
verilog/operand_resolve.sv
verilog/issue_hazard.sv
verilog/issue_dispatch.sv
verilog/issue_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_issue_unit.sv

//--- Makefile
TOP = tb_issue_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_issue_unit.sv
`timescale 1ns/100ps

module tb_issue_unit
	import issue_pkg::*;
();

typedef struct packed {
	word_t instr;
	word_t curr_pc;
	logic instr_is_new;
	logic predict;
	reg_read_t sr1_in;
	reg_read_t sr2_in;
	reg_read_t dest_in;
	rob_lookup_t rob_sr1;
	rob_lookup_t rob_sr2;
	logic rob_full;
	rob_tag_t rob_addr;
	logic [ALU_STATIONS-1:0] alu_busy;
	logic ldst_full;
	cdb_t cdb;
} stim_t;

typedef struct packed {
	logic stall;
	fetch_redirect_t redirect;
	alu_issue_t alu;
	ldst_issue_t ldst;
	rob_issue_t rob;
	reg_claim_t claim;
} expect_t;

logic clk;
logic reset;
stim_t drive;
logic stall;
reg_idx_t sr1;
reg_idx_t sr2;
reg_idx_t reg_dest;
rob_tag_t rob_sr1_addr;
rob_tag_t rob_sr2_addr;
alu_issue_t alu;
ldst_issue_t ldst;
rob_issue_t rob;
reg_claim_t claim;
fetch_redirect_t redirect;

stim_t stim[$];
expect_t expv[$];
string names[$];
stim_t s; // Entry under construction
expect_t e;
logic [31:0] rng_state = 32'd45;
int errors = 0;
bit built = 1'b0;

tb_clock_gen clock_gen
(
	.clk(clk),
	.reset(reset)
);

issue_unit DUT
(
	.clk(clk),
	.reset(reset),
	.instr(drive.instr),
	.curr_pc(drive.curr_pc),
	.instr_is_new(drive.instr_is_new),
	.predict(drive.predict),
	.sr1_in(drive.sr1_in),
	.sr2_in(drive.sr2_in),
	.dest_in(drive.dest_in),
	.rob_sr1(drive.rob_sr1),
	.rob_sr2(drive.rob_sr2),
	.rob_full(drive.rob_full),
	.rob_addr(drive.rob_addr),
	.alu_busy(drive.alu_busy),
	.ldst_full(drive.ldst_full),
	.cdb(drive.cdb),
	.stall(stall),
	.sr1(sr1),
	.sr2(sr2),
	.reg_dest(reg_dest),
	.rob_sr1_addr(rob_sr1_addr),
	.rob_sr2_addr(rob_sr2_addr),
	.alu(alu),
	.ldst(ldst),
	.rob(rob),
	.claim(claim),
	.redirect(redirect)
);

function automatic word_t xorshift_word();
	rng_state ^= rng_state << 13;
	rng_state ^= rng_state >> 17;
	rng_state ^= rng_state << 5;
	return rng_state[15:0];
endfunction

function automatic operand_t ready_opnd(word_t v);
	return '{ready: 1'b1, value: v, tag: '0};
endfunction

function automatic operand_t waiting_opnd(rob_tag_t t);
	return '{ready: 1'b0, value: '0, tag: t};
endfunction

// Idle machine state with fresh data words, producer tags 1, 2 and 3
task automatic new_entry(word_t instr, logic is_new);
	s = '0;
	s.instr = instr;
	s.curr_pc = xorshift_word() & 16'hFFFE;
	s.instr_is_new = is_new;
	s.sr1_in = '{busy: 1'b0, data: xorshift_word(), rob_tag: 3'd1};
	s.sr2_in = '{busy: 1'b0, data: xorshift_word(), rob_tag: 3'd2};
	s.dest_in = '{busy: 1'b0, data: xorshift_word(), rob_tag: 3'd3};
	s.rob_sr1.value = xorshift_word();
	s.rob_sr2.value = xorshift_word();
	s.cdb.data = xorshift_word();
	s.rob_addr = rob_tag_t'(xorshift_word()) | 3'd4; // Never one of the register tags
	e = '0;
endtask

task automatic add_entry(string name);
	names.push_back(name);
	stim.push_back(s);
	expv.push_back(e);
endtask

task automatic busy_sources(logic rob_done);
	s.sr1_in.busy = 1'b1;
	s.sr2_in.busy = 1'b1;
	s.rob_sr1.valid = rob_done;
	s.rob_sr2.valid = rob_done;
endtask

task automatic expect_alu(opcode_e op, station_id_t st, operand_t j, operand_t k);
	e.alu = '{valid: 1'b1, station: st, opcode: op, j: j, k: k, dest: s.rob_addr};
	e.rob = '{write: 1'b1, opcode: op, dest: s.instr[11:9], value: '0};
	e.claim = '{claim: 1'b1, idx: s.instr[11:9], tag: s.rob_addr};
endtask

task automatic expect_ldst(opcode_e op, operand_t base_op, operand_t src_op, word_t offset);
	logic store;
	store = (op == op_str);
	e.ldst = '{write: 1'b1, opcode: op, base: base_op, src: src_op, offset: offset,
		dest: store ? '0 : s.rob_addr};
	e.rob = '{write: 1'b1, opcode: op, dest: store ? '0 : s.instr[11:9], value: '0};
	if (!store)
	begin
		e.claim = '{claim: 1'b1, idx: s.instr[11:9], tag: s.rob_addr};
	end
endtask

task automatic expect_branch(word_t target, logic predicted);
	e.rob = '{write: 1'b1, opcode: op_br, dest: s.instr[11:9],
		value: predicted ? s.curr_pc : target};
	if (predicted)
	begin
		e.redirect = '{redirect: 1'b1, target: target};
	end
endtask

task automatic build_table();
	new_entry({op_add, 3'd1, 3'd2, 3'b000, 3'd3}, 1'b0);
	add_entry("idle_after_reset");
	new_entry({op_add, 3'd1, 3'd2, 3'b000, 3'd3}, 1'b1); // First issue, no bubble
	expect_alu(op_add, 2'd0, ready_opnd(s.sr1_in.data), ready_opnd(s.sr2_in.data));
	add_entry("add_reg");
	new_entry({op_and, 3'd4, 3'd5, 1'b1, 5'b10110}, 1'b1); // Immediate of -10
	s.alu_busy = 3'b101;
	expect_alu(op_and, 2'd1, ready_opnd(s.sr1_in.data), ready_opnd(16'hFFF6));
	add_entry("and_imm");
	new_entry({op_not, 3'd6, 3'd7, 6'b111111}, 1'b1);
	s.alu_busy = 3'b011;
	expect_alu(op_not, 2'd2, ready_opnd(s.sr1_in.data), ready_opnd(16'hFFFF));
	add_entry("not_op");

	// Operand priority on both sources
	new_entry({op_add, 3'd2, 3'd3, 3'b000, 3'd4}, 1'b1);
	busy_sources(1'b1);
	s.cdb = '{valid: 1'b1, tag: 3'd1, data: s.cdb.data};
	expect_alu(op_add, 2'd0, ready_opnd(s.cdb.data), ready_opnd(s.rob_sr2.value));
	add_entry("cdb_hit_j_rob_k");
	new_entry({op_add, 3'd2, 3'd3, 3'b000, 3'd4}, 1'b1);
	busy_sources(1'b1);
	s.cdb = '{valid: 1'b1, tag: 3'd2, data: s.cdb.data};
	expect_alu(op_add, 2'd0, ready_opnd(s.rob_sr1.value), ready_opnd(s.cdb.data));
	add_entry("rob_j_cdb_hit_k");
	new_entry({op_and, 3'd5, 3'd3, 3'b000, 3'd4}, 1'b1);
	busy_sources(1'b0);
	s.cdb = '{valid: 1'b1, tag: 3'd6, data: s.cdb.data}; // Unrelated producer
	expect_alu(op_and, 2'd0, waiting_opnd(3'd1), waiting_opnd(3'd2));
	add_entry("both_waiting");

	// Loads and stores
	new_entry({op_ldr, 3'd2, 3'd3, 6'b111101}, 1'b1);
	expect_ldst(op_ldr, ready_opnd(s.sr1_in.data), '0, 16'hFFFA);
	add_entry("ldr_offset");
	new_entry({op_str, 3'd4, 3'd1, 6'b000111}, 1'b1);
	s.sr1_in.busy = 1'b1;
	s.dest_in.busy = 1'b1;
	s.cdb = '{valid: 1'b1, tag: 3'd3, data: s.cdb.data};
	expect_ldst(op_str, waiting_opnd(3'd1), ready_opnd(s.cdb.data), 16'h000E);
	add_entry("str_src_from_dest");
	new_entry({op_str, 3'd7, 3'd0, 6'b100000}, 1'b1);
	s.dest_in.busy = 1'b1;
	expect_ldst(op_str, ready_opnd(s.sr1_in.data), waiting_opnd(3'd3), 16'hFFC0);
	add_entry("str_src_waiting");

	// Structural hazards
	new_entry({op_add, 3'd1, 3'd2, 3'b000, 3'd3}, 1'b1);
	s.rob_full = 1'b1;
	e.stall = 1'b1;
	add_entry("rob_full");
	new_entry({op_add, 3'd1, 3'd2, 3'b000, 3'd3}, 1'b1);
	s.alu_busy = 3'b111;
	e.stall = 1'b1;
	add_entry("alu_all_busy");
	new_entry({op_ldr, 3'd1, 3'd2, 6'b000001}, 1'b1);
	s.ldst_full = 1'b1;
	e.stall = 1'b1;
	add_entry("ldst_full");
	new_entry({op_add, 3'd3, 3'd4, 3'b000, 3'd5}, 1'b1);
	s.ldst_full = 1'b1; // Only memory ops care
	expect_alu(op_add, 2'd0, ready_opnd(s.sr1_in.data), ready_opnd(s.sr2_in.data));
	add_entry("add_ignores_ldst_full");
	new_entry({op_add, 3'd1, 3'd2, 3'b000, 3'd3}, 1'b0);
	s.rob_full = 1'b1;
	add_entry("rob_full_not_new");

	// Branches, offset9 of +5 and -10
	new_entry({op_br, 3'b111, 9'h005}, 1'b1);
	expect_branch(s.curr_pc + 16'd10, 1'b0);
	add_entry("br_not_predicted");
	new_entry({op_br, 3'b010, 9'h1F6}, 1'b1);
	s.predict = 1'b1;
	expect_branch(s.curr_pc - 16'd20, 1'b1);
	add_entry("br_predicted");
	new_entry({op_add, 3'd1, 3'd2, 3'b000, 3'd3}, 1'b1);
	add_entry("bubble_after_br");
	new_entry({op_add, 3'd1, 3'd2, 3'b000, 3'd3}, 1'b1);
	expect_alu(op_add, 2'd0, ready_opnd(s.sr1_in.data), ready_opnd(s.sr2_in.data));
	add_entry("add_after_bubble");
endtask

task automatic compare(string name, string field, logic [63:0] expected, logic [63:0] actual);
	if (expected !== actual)
	begin
		errors++;
		$display("Mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
	end
endtask

task automatic check_entry(int i);
	string n;
	rob_tag_t sr2_tag;
	n = names[i];
	// Store data register is read through the dest field
	sr2_tag = (stim[i].instr[15:12] == op_str) ? stim[i].dest_in.rob_tag
		: stim[i].sr2_in.rob_tag;
	compare(n, "stall", 64'(expv[i].stall), 64'(stall));
	compare(n, "redirect", 64'(expv[i].redirect), 64'(redirect));
	compare(n, "alu", 64'(expv[i].alu), 64'(alu));
	compare(n, "ldst", 64'(expv[i].ldst), 64'(ldst));
	compare(n, "rob", 64'(expv[i].rob), 64'(rob));
	compare(n, "claim", 64'(expv[i].claim), 64'(claim));
	compare(n, "sr1", 64'(stim[i].instr[8:6]), 64'(sr1));
	compare(n, "sr2", 64'(stim[i].instr[2:0]), 64'(sr2));
	compare(n, "reg_dest", 64'(stim[i].instr[11:9]), 64'(reg_dest));
	compare(n, "rob_sr1_addr", 64'(stim[i].sr1_in.rob_tag), 64'(rob_sr1_addr));
	compare(n, "rob_sr2_addr", 64'(sr2_tag), 64'(rob_sr2_addr));
endtask

initial
begin
	drive = '0;
	build_table();
	built = 1'b1;
	wait (reset === 1'b0);
	foreach (stim[i])
	begin
		@(negedge clk);
		drive = stim[i];
		#40; // Just ahead of the next rising edge
		check_entry(i);
	end
	$display("Finished %0d entries with %0d errors", names.size(), errors);
	if (errors == 0)
	begin
		$display("TEST RESULT: PASS");
	end
	else
	begin
		$display("TEST RESULT: FAIL");
	end
	$finish;
end

initial
begin
	wait (built);
	#((names.size() + 10) * 100);
	$display("Timeout: the table did not finish within %0d clock cycles", names.size() + 10);
	$display("TEST RESULT: FAIL");
	$finish;
end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk,
	output logic reset
);

initial
begin
	clk = 1'b0;
	forever #50 clk = ~clk; // 100 ns period
end

// Held over four rising edges
initial
begin
	reset <= 1'b1;
	repeat (4) @(posedge clk);
	reset <= 1'b0;
end

endmodule

//--- verilog/issue_unit.sv
`timescale 1ns/100ps

module issue_unit
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input word_t instr,
	input word_t curr_pc,
	input logic instr_is_new,
	input logic predict,
	input reg_read_t sr1_in,
	input reg_read_t sr2_in,
	input reg_read_t dest_in,
	input rob_lookup_t rob_sr1,
	input rob_lookup_t rob_sr2,
	input logic rob_full,
	input rob_tag_t rob_addr,
	input logic [ALU_STATIONS-1:0] alu_busy,
	input logic ldst_full,
	input cdb_t cdb,
	output logic stall,
	output reg_idx_t sr1,
	output reg_idx_t sr2,
	output reg_idx_t reg_dest,
	output rob_tag_t rob_sr1_addr,
	output rob_tag_t rob_sr2_addr,
	output alu_issue_t alu,
	output ldst_issue_t ldst,
	output rob_issue_t rob,
	output reg_claim_t claim,
	output fetch_redirect_t redirect
);

decoded_t dec;
logic issue_go;
station_id_t station_id;

// Register file read indices straight from the fields
assign sr1 = dec.sr1;
assign sr2 = dec.sr2;
assign reg_dest = dec.dest;
assign rob_sr1_addr = sr1_in.rob_tag;

instr_decode decode
(
	.instr(instr),
	.dec(dec)
);

issue_hazard hazard
(
	.clk(clk),
	.reset(reset),
	.dec(dec),
	.instr_is_new(instr_is_new),
	.predict(predict),
	.rob_full(rob_full),
	.alu_busy(alu_busy),
	.ldst_full(ldst_full),
	.issue_go(issue_go),
	.stall(stall),
	.station_id(station_id)
);

issue_dispatch dispatch
(
	.dec(dec),
	.issue_go(issue_go),
	.station_id(station_id),
	.curr_pc(curr_pc),
	.rob_addr(rob_addr),
	.predict(predict),
	.sr1_in(sr1_in),
	.sr2_in(sr2_in),
	.dest_in(dest_in),
	.rob_sr1(rob_sr1),
	.rob_sr2(rob_sr2),
	.cdb(cdb),
	.rob_sr2_addr(rob_sr2_addr),
	.alu(alu),
	.ldst(ldst),
	.rob(rob),
	.claim(claim),
	.redirect(redirect)
);

endmodule

//--- verilog/issue_dispatch.sv
`timescale 1ns/100ps

module issue_dispatch
	import issue_pkg::*;
(
	input decoded_t dec,
	input logic issue_go,
	input station_id_t station_id,
	input word_t curr_pc,
	input rob_tag_t rob_addr,
	input logic predict,
	input reg_read_t sr1_in,
	input reg_read_t sr2_in,
	input reg_read_t dest_in,
	input rob_lookup_t rob_sr1,
	input rob_lookup_t rob_sr2,
	input cdb_t cdb,
	output rob_tag_t rob_sr2_addr,
	output alu_issue_t alu,
	output ldst_issue_t ldst,
	output rob_issue_t rob,
	output reg_claim_t claim,
	output fetch_redirect_t redirect
);

reg_read_t src2_reg; // Second source, store data for STR
operand_t opnd_a;
operand_t opnd_b;
operand_t imm_opnd;
logic is_store;
word_t branch_target;

assign is_store = (dec.opcode == op_str);
assign src2_reg = is_store ? dest_in : sr2_in;
assign rob_sr2_addr = src2_reg.rob_tag;

assign imm_opnd = '{ready: 1'b1, value: dec.imm5, tag: '0};
assign branch_target = curr_pc + dec.offset9;

operand_resolve resolve_a
(
	.reg_in(sr1_in),
	.cdb(cdb),
	.rob(rob_sr1),
	.opnd(opnd_a)
);

operand_resolve resolve_b
(
	.reg_in(src2_reg),
	.cdb(cdb),
	.rob(rob_sr2),
	.opnd(opnd_b)
);

always_comb
begin
	alu = '0;
	ldst = '0;
	rob = '0;
	claim = '0;
	redirect = '0;

	if (issue_go)
	begin
		case (dec.cls)
			cls_alu:
			begin
				alu.valid = 1'b1;
				alu.station = station_id;
				alu.opcode = dec.opcode;
				alu.j = opnd_a;
				alu.k = dec.imm_sel ? imm_opnd : opnd_b;
				alu.dest = rob_addr;

				rob.write = 1'b1;
				rob.opcode = dec.opcode;
				rob.dest = dec.dest;

				claim.claim = 1'b1;
				claim.idx = dec.dest;
				claim.tag = rob_addr;
			end
			cls_ldst:
			begin
				ldst.write = 1'b1;
				ldst.opcode = dec.opcode;
				ldst.base = opnd_a;
				ldst.offset = dec.offset6;
				if (is_store)
				begin
					ldst.src = opnd_b; // Data comes from the dest field
				end
				else
				begin
					ldst.dest = rob_addr;
				end

				rob.write = 1'b1;
				rob.opcode = dec.opcode;
				rob.dest = is_store ? '0 : dec.dest;

				// A store produces no register value
				claim.claim = !is_store;
				claim.idx = is_store ? '0 : dec.dest;
				claim.tag = is_store ? '0 : rob_addr;
			end
			cls_branch:
			begin
				rob.write = 1'b1;
				rob.opcode = dec.opcode;
				rob.dest = dec.dest; // NZP bits ride along in the dest field
				// ROB keeps the path not taken by fetch for recovery
				rob.value = predict ? curr_pc : branch_target;

				redirect.redirect = predict;
				redirect.target = predict ? branch_target : '0;
			end
			default:
			begin
			end
		endcase
	end
end

// Classes are exclusive, one queue per instruction
always_comb
begin
	one_queue_write: assert (!(alu.valid && ldst.write));
end

endmodule

//--- verilog/issue_hazard.sv
`timescale 1ns/100ps

module issue_hazard
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input decoded_t dec,
	input logic instr_is_new,
	input logic predict,
	input logic rob_full,
	input logic [ALU_STATIONS-1:0] alu_busy,
	input logic ldst_full,
	output logic issue_go,
	output logic stall,
	output station_id_t station_id
);

logic bubble; // Slot after a predicted-taken branch
logic hazard;
logic can_issue;
logic alu_hazard;
logic ldst_hazard;

assign alu_hazard = (dec.cls == cls_alu) && (&alu_busy);
assign ldst_hazard = (dec.cls == cls_ldst) && ldst_full;
assign hazard = rob_full || alu_hazard || ldst_hazard;

// Fetch sends nothing useful during the bubble
assign can_issue = instr_is_new && !bubble;

assign stall = can_issue && hazard;
assign issue_go = can_issue && !hazard;

always_ff @(posedge clk)
begin
	if (reset)
	begin
		bubble <= 1'b0;
	end
	else
	begin
		bubble <= issue_go && (dec.cls == cls_branch) && predict;
	end
end

// Lowest numbered free station wins
always_comb
begin
	station_id = '0;
	for (int i = ALU_STATIONS - 1; i >= 0; i--)
	begin
		if (!alu_busy[i])
		begin
			station_id = station_id_t'(i);
		end
	end
end

stall_excludes_issue: assert property (
	@(posedge clk) disable iff (reset) !(stall && issue_go)
);

// Issue is blocked in the bubble, so it cannot chain
bubble_single_cycle: assert property (
	@(posedge clk) disable iff (reset) bubble |=> !bubble
);

endmodule

//--- verilog/operand_resolve.sv
`timescale 1ns/100ps

module operand_resolve
	import issue_pkg::*;
(
	input reg_read_t reg_in,
	input cdb_t cdb,
	input rob_lookup_t rob,
	output operand_t opnd
);

logic cdb_hit;

// Result being broadcast this cycle by the producer
assign cdb_hit = cdb.valid && (cdb.tag == reg_in.rob_tag);

always_comb
begin
	opnd.ready = 1'b1;
	opnd.value = '0;
	opnd.tag = '0;

	if (!reg_in.busy)
	begin
		opnd.value = reg_in.data;
	end
	else if (cdb_hit)
	begin
		opnd.value = cdb.data;
	end
	else if (rob.valid)
	begin
		opnd.value = rob.value; // Completed but not yet committed
	end
	else
	begin
		opnd.ready = 1'b0;
		opnd.tag = reg_in.rob_tag;
	end
end

endmodule

//--- verilog/instr_decode.sv
`timescale 1ns/100ps

module instr_decode
	import issue_pkg::*;
(
	input word_t instr,
	output decoded_t dec
);

opcode_e opcode;

assign opcode = opcode_e'(instr[15:12]);

always_comb
begin
	dec.opcode = opcode;
	dec.dest = instr[11:9];
	dec.sr1 = instr[8:6];
	dec.sr2 = instr[2:0];
	dec.imm_sel = instr[5];

	// Sign extension of the immediate
	dec.imm5 = {{(WORD_WIDTH-5){instr[4]}}, instr[4:0]};

	// Word offsets, shifted left once
	dec.offset6 = {{(WORD_WIDTH-7){instr[5]}}, instr[5:0], 1'b0};
	dec.offset9 = {{(WORD_WIDTH-10){instr[8]}}, instr[8:0], 1'b0};
end

always_comb
begin
	case (opcode)
		op_add, op_and, op_not:
		begin
			dec.cls = cls_alu;
		end
		op_ldr, op_str:
		begin
			dec.cls = cls_ldst;
		end
		op_br:
		begin
			dec.cls = cls_branch;
		end
		default:
		begin
			dec.cls = cls_none; // LDI, STI, TRAP, JMP and the rest
		end
	endcase
end

endmodule

//--- verilog/issue_pkg.sv
package issue_pkg;

localparam int WORD_WIDTH = 16;
localparam int REG_WIDTH = 3;
localparam int TAG_WIDTH = 3;
localparam int ALU_STATIONS = 3;

typedef logic [WORD_WIDTH-1:0] word_t;
typedef logic [REG_WIDTH-1:0] reg_idx_t;
typedef logic [TAG_WIDTH-1:0] rob_tag_t;
typedef logic [$clog2(ALU_STATIONS)-1:0] station_id_t;

// LC-3b opcode field, only the issued subset is named
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001
} opcode_e;

typedef enum logic [1:0] {
	cls_alu,
	cls_ldst,
	cls_branch,
	cls_none // Dropped or unknown opcodes
} issue_class_e;

typedef struct packed {
	logic busy;
	word_t data;
	rob_tag_t rob_tag; // Producer entry while busy
} reg_read_t;

typedef struct packed {
	logic valid;
	rob_tag_t tag;
	word_t data;
} cdb_t;

typedef struct packed {
	logic valid; // Entry has completed
	word_t value;
} rob_lookup_t;

typedef struct packed {
	opcode_e opcode;
	issue_class_e cls;
	reg_idx_t dest;
	reg_idx_t sr1;
	reg_idx_t sr2;
	logic imm_sel;
	word_t imm5;
	word_t offset6; // Already doubled
	word_t offset9; // Already doubled
} decoded_t;

typedef struct packed {
	logic ready;
	word_t value;
	rob_tag_t tag; // Producer to wait on when not ready
} operand_t;

typedef struct packed {
	logic valid;
	station_id_t station;
	opcode_e opcode;
	operand_t j;
	operand_t k;
	rob_tag_t dest;
} alu_issue_t;

typedef struct packed {
	logic write;
	opcode_e opcode;
	operand_t base;
	operand_t src;
	word_t offset;
	rob_tag_t dest; // Zero for stores
} ldst_issue_t;

typedef struct packed {
	logic write;
	opcode_e opcode;
	reg_idx_t dest;
	word_t value;
} rob_issue_t;

typedef struct packed {
	logic claim;
	reg_idx_t idx;
	rob_tag_t tag;
} reg_claim_t;

typedef struct packed {
	logic redirect;
	word_t target;
} fetch_redirect_t;

endpackage
